//--- source/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// ------------------------------
	// Bus types
	// ------------------------------

	// Wishbone byte address and data
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	// CSR word address, bank on top of register index
	typedef logic [13:0] csr_addr_t;
	typedef logic [3:0] csr_bank_t;
	typedef logic [9:0] csr_reg_t;

	// PCB revision over the three buttons
	typedef logic [6:0] gpio_in_t;
	// LED pair
	typedef logic [1:0] gpio_out_t;
	// Reset hold and flash counters
	typedef logic [6:0] rst_cnt_t;

	// ------------------------------
	// System controller map
	// ------------------------------
	localparam csr_bank_t CSR_BANK_SYSCTL = 4'd1;
	localparam csr_reg_t REG_GPIO_IN = 10'd0;
	localparam csr_reg_t REG_GPIO_OUT = 10'd1;
	localparam csr_reg_t REG_GPIO_IRQ_EN = 10'd2;
	localparam csr_reg_t REG_TIMER_CTRL = 10'd3;
	localparam csr_reg_t REG_TIMER_COMPARE = 10'd4;
	localparam csr_reg_t REG_TIMER_COUNTER = 10'd5;
	localparam csr_reg_t REG_SYSTEM_ID = 10'd6;
	localparam csr_reg_t REG_HARD_RESET = 10'd7;

	localparam wb_data_t SYSTEM_ID = 32'h534f434c;

	// Short reset lengths, flash comes out first
	localparam rst_cnt_t RST_HOLD_CYCLES = 7'd64;
	localparam rst_cnt_t FLASH_RST_CYCLES = 7'd16;

	typedef enum logic [1:0] {
		BRG_IDLE,
		BRG_ACCESS,
		BRG_ACK
	} bridge_state_e;

endpackage

`default_nettype wire

//--- source/soc_ifs.sv
`default_nettype none

// Narrow CSR bus, one bridge and one slave
interface csr_if;
	soc_pkg::csr_addr_t csr_a;
	logic csr_we;
	soc_pkg::wb_data_t csr_dw;
	// Registered by the slave, valid a cycle after csr_a
	soc_pkg::wb_data_t csr_dr;

	modport bridge (output csr_a, output csr_we, output csr_dw, input csr_dr);
	modport slave (input csr_a, input csr_we, input csr_dw, output csr_dr);
endinterface

// Register bank to interval timer
interface timer_if;
	logic enable;
	logic autoreload;
	soc_pkg::wb_data_t compare;
	// One-cycle load strobe
	logic load;
	soc_pkg::wb_data_t load_value;
	soc_pkg::wb_data_t count;
	// One-cycle expiry pulse
	logic expired;

	modport regs (
		output enable, output autoreload, output compare,
		output load, output load_value,
		input count, input expired
	);
	modport timer (
		input enable, input autoreload, input compare,
		input load, input load_value,
		output count, output expired
	);
endinterface

`default_nettype wire

//--- source/reset_gen.sv
`default_nettype none

module reset_gen (
	input wire logic sys_clk,
	input wire logic trigger_reset,
	input wire logic hard_reset_i,
	input wire logic [2:0] btn_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic rst_req;
	soc_pkg::rst_cnt_t hold_cnt;
	soc_pkg::rst_cnt_t flash_cnt;

	// External trigger, register strobe or all buttons held
	always_ff @(posedge sys_clk) begin
		rst_req <= trigger_reset | hard_reset_i | (&btn_i);
	end

	// ------------------------------
	// System reset hold
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			hold_cnt <= soc_pkg::RST_HOLD_CYCLES;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 7'd1;
		end
		// Held until the count drains
		sys_rst_o <= (hold_cnt != '0);
	end

	// ------------------------------
	// Flash reset release
	// ------------------------------
	// Flash needs time before the first fetch, so it lets go early
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			flash_cnt <= '0;
		end else if (flash_cnt != soc_pkg::FLASH_RST_CYCLES) begin
			flash_cnt <= flash_cnt + 7'd1;
		end
		flash_rst_n_o <= (flash_cnt == soc_pkg::FLASH_RST_CYCLES);
	end

endmodule

`default_nettype wire

//--- source/csr_bridge.sv
`default_nettype none

module csr_bridge (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	input wire soc_pkg::wb_addr_t wb_adr_i,
	input wire soc_pkg::wb_data_t wb_dat_i,
	input wire logic wb_we_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	output soc_pkg::wb_data_t wb_dat_o,
	output logic wb_ack_o,
	csr_if.bridge csr
);

	soc_pkg::bridge_state_e state;
	logic wb_req;

	// Ack cycle still shows the request that is being closed
	assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

	// ------------------------------
	// Control FSM
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= soc_pkg::BRG_IDLE;
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
		end else begin
			// Both are single-cycle strobes
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
			case (state)
				soc_pkg::BRG_IDLE: begin
					if (wb_req) begin
						csr.csr_we <= wb_we_i;
						state <= soc_pkg::BRG_ACCESS;
					end
				end
				// Slave registers csr_dr here
				soc_pkg::BRG_ACCESS: state <= soc_pkg::BRG_ACK;
				soc_pkg::BRG_ACK: begin
					wb_ack_o <= 1'b1;
					state <= soc_pkg::BRG_IDLE;
				end
				default: state <= soc_pkg::BRG_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Address and data path
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if ((state == soc_pkg::BRG_IDLE) && wb_req) begin
			// Byte address to word address
			csr.csr_a <= wb_adr_i[15:2];
			csr.csr_dw <= wb_dat_i;
		end
		if (state == soc_pkg::BRG_ACK) begin
			wb_dat_o <= csr.csr_dr;
		end
	end

endmodule

`default_nettype wire

//--- source/sysctl_regs.sv
`default_nettype none

module sysctl_regs (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	input wire soc_pkg::gpio_in_t gpio_in_i,
	output soc_pkg::gpio_out_t gpio_out_o,
	output logic gpio_irq_o,
	output logic hard_reset_o,
	csr_if.slave csr,
	timer_if.regs tmr
);

	soc_pkg::csr_bank_t bank;
	soc_pkg::csr_reg_t reg_idx;
	logic bank_sel;
	logic wr_en;
	soc_pkg::gpio_in_t irq_en;
	soc_pkg::gpio_in_t gpio_s1;
	soc_pkg::gpio_in_t gpio_s2;
	soc_pkg::gpio_in_t gpio_prev;

	// Bank decode
	assign bank = csr.csr_a[13:10];
	assign reg_idx = csr.csr_a[9:0];
	assign bank_sel = (bank == soc_pkg::CSR_BANK_SYSCTL);
	assign wr_en = csr.csr_we & bank_sel;

	// Counter write goes straight to the timer
	assign tmr.load = wr_en & (reg_idx == soc_pkg::REG_TIMER_COUNTER);
	assign tmr.load_value = csr.csr_dw;

	// ------------------------------
	// GPIO sync and edge detect
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_s1 <= gpio_in_i;
		gpio_s2 <= gpio_s1;
		gpio_prev <= gpio_s2;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_irq_o <= 1'b0;
		end else begin
			// Any masked bit that moved
			gpio_irq_o <= |((gpio_s2 ^ gpio_prev) & irq_en);
		end
	end

	// ------------------------------
	// Writable registers
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			irq_en <= '0;
			tmr.enable <= 1'b0;
			tmr.autoreload <= 1'b0;
			tmr.compare <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= 1'b0;
			// One-shot stops itself, a CPU write below still wins
			if (tmr.expired & ~tmr.autoreload) begin
				tmr.enable <= 1'b0;
			end
			if (wr_en) begin
				case (reg_idx)
					soc_pkg::REG_GPIO_OUT: gpio_out_o <= csr.csr_dw[1:0];
					soc_pkg::REG_GPIO_IRQ_EN: irq_en <= csr.csr_dw[6:0];
					soc_pkg::REG_TIMER_CTRL: begin
						tmr.enable <= csr.csr_dw[0];
						tmr.autoreload <= csr.csr_dw[1];
					end
					soc_pkg::REG_TIMER_COMPARE: tmr.compare <= csr.csr_dw;
					// Data ignored, the write itself is the request
					soc_pkg::REG_HARD_RESET: hard_reset_o <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// Read mux, zero outside the bank and on unmapped indices
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (bank_sel) begin
			case (reg_idx)
				soc_pkg::REG_GPIO_IN: csr.csr_dr <= {25'd0, gpio_s2};
				soc_pkg::REG_GPIO_OUT: csr.csr_dr <= {30'd0, gpio_out_o};
				soc_pkg::REG_GPIO_IRQ_EN: csr.csr_dr <= {25'd0, irq_en};
				soc_pkg::REG_TIMER_CTRL: csr.csr_dr <= {30'd0, tmr.autoreload, tmr.enable};
				soc_pkg::REG_TIMER_COMPARE: csr.csr_dr <= tmr.compare;
				soc_pkg::REG_TIMER_COUNTER: csr.csr_dr <= tmr.count;
				soc_pkg::REG_SYSTEM_ID: csr.csr_dr <= soc_pkg::SYSTEM_ID;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/sys_timer.sv
`default_nettype none

module sys_timer (
	input wire logic sys_clk,
	input wire logic sys_rst_i,
	timer_if.timer tmr
);

	logic running;
	logic match;

	// One-shot waits here while the register bank drops enable
	assign running = tmr.enable & ~(tmr.expired & ~tmr.autoreload);
	assign match = (tmr.count == tmr.compare);

	// ------------------------------
	// Count and expiry
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			tmr.count <= '0;
			tmr.expired <= 1'b0;
		end else begin
			tmr.expired <= 1'b0;
			if (tmr.load) begin
				// Software load beats counting
				tmr.count <= tmr.load_value;
			end else if (running) begin
				if (match) begin
					// Period is compare+1 cycles
					tmr.count <= '0;
					tmr.expired <= 1'b1;
				end else begin
					tmr.count <= tmr.count + 32'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/soc_top.sv
`default_nettype none

module soc_top (
	input wire logic sys_clk,
	input wire logic trigger_reset,
	// Wishbone slave port of the CSR bridge
	input wire soc_pkg::wb_addr_t wb_adr_i,
	input wire soc_pkg::wb_data_t wb_dat_i,
	input wire logic wb_we_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	output soc_pkg::wb_data_t wb_dat_o,
	output logic wb_ack_o,
	// Board IO
	input wire logic [2:0] btn_i,
	input wire logic [3:0] pcb_rev_i,
	output logic [1:0] led_o,
	// Interrupts and resets
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic hard_reset;

	csr_if csr_bus ();
	timer_if tmr_bus ();

	// ------------------------------
	// Reset
	// ------------------------------
	reset_gen u_reset_gen (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_i(hard_reset),
		.btn_i(btn_i),
		.sys_rst_o(sys_rst_o),
		.flash_rst_n_o(flash_rst_n_o)
	);

	// ------------------------------
	// Bus and peripherals
	// ------------------------------
	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.csr(csr_bus.bridge)
	);

	// Revision on top, buttons in the low bits
	sysctl_regs u_sysctl_regs (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.gpio_in_i({pcb_rev_i, btn_i}),
		.gpio_out_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.hard_reset_o(hard_reset),
		.csr(csr_bus.slave),
		.tmr(tmr_bus.regs)
	);

	sys_timer u_sys_timer (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.tmr(tmr_bus.timer)
	);

	assign timer_irq_o = tmr_bus.expired;

endmodule

`default_nettype wire

//--- tests/soc_chk.sv
`default_nettype none

module soc_chk (
	input wire logic sys_clk,
	input wire logic sys_rst_o,
	input wire logic wb_ack_o,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic timer_irq_o,
	input wire logic [1:0] led_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// ------------------------------
	// Wishbone handshake
	// ------------------------------
	ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst_o !== 1'b0)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb_ack_o high two cycles in a row");

	// Ack only inside an open cycle
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_o !== 1'b0)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o without cyc and stb");

	// ------------------------------
	// Interrupt and reset outputs
	// ------------------------------
	timer_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst_o !== 1'b0)
		timer_irq_o |=> !timer_irq_o)
		else $error("timer_irq_o longer than one cycle");

	// Register bank clears one cycle into reset
	led_in_reset: assert property (@(posedge sys_clk)
		(sys_rst_o && $past(sys_rst_o)) |-> (led_o == 2'b00))
		else $error("led_o not zero during reset");

endmodule

bind soc_top soc_chk u_soc_chk (
	.sys_clk(sys_clk),
	.sys_rst_o(sys_rst_o),
	.wb_ack_o(wb_ack_o),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.timer_irq_o(timer_irq_o),
	.led_o(led_o)
);

`default_nettype wire

//--- tests/tb_checker.sv
`default_nettype none

module tb_checker (
	input wire logic sys_clk,
	input wire logic sys_rst_o,
	input wire logic [31:0] wb_adr_i,
	input wire logic [31:0] wb_dat_i,
	input wire logic wb_we_i,
	input wire logic wb_cyc_i,
	input wire logic [31:0] wb_dat_o,
	input wire logic wb_ack_o,
	input wire logic [2:0] btn_i,
	input wire logic [3:0] pcb_rev_i,
	input wire logic [1:0] led_o,
	input wire logic timer_irq_o
);
	timeunit 1ns;
	timeprecision 100ps;

	int mismatch_count = 0;
	int failure_count = 0;

	// Register map model
	logic [1:0] m_gpio_out;
	logic [6:0] m_irq_en;
	logic m_enable;
	logic m_autoreload;
	logic [31:0] m_compare;

	// ------------------------------
	// Reporting
	// ------------------------------
	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic expect_true(input bit ok, input string what);
		if (!ok) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s", $time, what);
		end
	endtask

	task automatic note_failure(input string what);
		failure_count++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic print_summary();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
	endtask

	// Expected read data, zero outside the sysctl bank
	function automatic logic [31:0] expected_read(input logic [13:0] a);
		logic [9:0] idx;
		idx = a[9:0];
		expected_read = '0;
		if (a[13:10] == soc_pkg::CSR_BANK_SYSCTL) begin
			case (idx)
				soc_pkg::REG_GPIO_IN: expected_read = {25'd0, pcb_rev_i, btn_i};
				soc_pkg::REG_GPIO_OUT: expected_read = {30'd0, m_gpio_out};
				soc_pkg::REG_GPIO_IRQ_EN: expected_read = {25'd0, m_irq_en};
				soc_pkg::REG_TIMER_CTRL: expected_read = {30'd0, m_autoreload, m_enable};
				soc_pkg::REG_TIMER_COMPARE: expected_read = m_compare;
				soc_pkg::REG_SYSTEM_ID: expected_read = soc_pkg::SYSTEM_ID;
				default: expected_read = '0;
			endcase
		end
	endfunction

	task automatic apply_write(input logic [13:0] a, input logic [31:0] d);
		if (a[13:10] == soc_pkg::CSR_BANK_SYSCTL) begin
			case (a[9:0])
				soc_pkg::REG_GPIO_OUT: m_gpio_out = d[1:0];
				soc_pkg::REG_GPIO_IRQ_EN: m_irq_en = d[6:0];
				soc_pkg::REG_TIMER_CTRL: begin
					m_enable = d[0];
					m_autoreload = d[1];
				end
				soc_pkg::REG_TIMER_COMPARE: m_compare = d;
				default: ;
			endcase
		end
	endtask

	// ------------------------------
	// Bus and output watcher
	// ------------------------------
	always @(posedge sys_clk) begin
		if (sys_rst_o !== 1'b0) begin
			// Model follows the register reset
			m_gpio_out = '0;
			m_irq_en = '0;
			m_enable = 1'b0;
			m_autoreload = 1'b0;
			m_compare = '0;
		end else begin
			// One-shot expiry drops enable, a write on the same edge wins
			if (timer_irq_o === 1'b1 && !m_autoreload) begin
				m_enable = 1'b0;
			end
			if (wb_ack_o === 1'b1) begin
				if (wb_we_i) begin
					apply_write(wb_adr_i[15:2], wb_dat_i);
				end else if (wb_adr_i[15:2] !=
					{soc_pkg::CSR_BANK_SYSCTL, soc_pkg::REG_TIMER_COUNTER}) begin
					compare_value($sformatf("read of %h", wb_adr_i), wb_dat_o,
						expected_read(wb_adr_i[15:2]));
				end
			end
			// LEDs only settled with no access in flight
			if (wb_cyc_i === 1'b0) begin
				compare_value("led_o", {30'd0, led_o}, {30'd0, m_gpio_out});
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	logic sys_clk;
	logic trigger_reset;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;
	logic [2:0] btn;
	logic [3:0] pcb_rev;
	logic [1:0] led;
	logic gpio_irq;
	logic timer_irq;
	logic sys_rst;
	logic flash_rst_n;
	logic [31:0] rng;

	soc_top DUT (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_we_i(wb_we),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.btn_i(btn),
		.pcb_rev_i(pcb_rev),
		.led_o(led),
		.gpio_irq_o(gpio_irq),
		.timer_irq_o(timer_irq),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n)
	);

	tb_checker u_checker (
		.sys_clk(sys_clk),
		.sys_rst_o(sys_rst),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_we_i(wb_we),
		.wb_cyc_i(wb_cyc),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.btn_i(btn),
		.pcb_rev_i(pcb_rev),
		.led_o(led),
		.timer_irq_o(timer_irq)
	);

	// 4 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Byte address of a CSR register
	function automatic logic [31:0] csr_addr(input logic [3:0] bank, input logic [9:0] idx);
		return {16'd0, bank, idx, 2'b00};
	endfunction

	task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
		output logic [31:0] rdata);
		int t;
		@(posedge sys_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= addr;
		wb_dat_w <= data;
		t = 0;
		rdata = '0;
		do begin
			@(posedge sys_clk);
			t++;
		end while (wb_ack !== 1'b1 && t < 20);
		if (wb_ack !== 1'b1) begin
			u_checker.note_failure("no Wishbone ack within 20 cycles");
		end else begin
			rdata = wb_dat_r;
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		// Strobe stays low for a cycle between accesses
		@(posedge sys_clk);
	endtask

	task automatic wb_write(input logic [9:0] idx, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, csr_addr(soc_pkg::CSR_BANK_SYSCTL, idx), data, unused);
	endtask

	task automatic wb_read(input logic [9:0] idx, output logic [31:0] data);
		bus_access(1'b0, csr_addr(soc_pkg::CSR_BANK_SYSCTL, idx), '0, data);
	endtask

	task automatic wait_sys_rst(input logic level, input int limit);
		int t;
		t = 0;
		while (sys_rst !== level && t < limit) begin
			@(posedge sys_clk);
			t++;
		end
		if (sys_rst !== level) begin
			u_checker.note_failure("sys_rst_o did not reach the expected level in time");
		end
	endtask

	// Cycles until the next timer pulse or the limit
	task automatic timer_gap(input int limit, output int n);
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
		end while (timer_irq !== 1'b1 && n < limit);
		if (timer_irq !== 1'b1) begin
			u_checker.note_failure("no timer interrupt within the timeout");
		end
	endtask

	task automatic count_pulses(input bit use_timer, input int window, output int n);
		n = 0;
		repeat (window) begin
			@(posedge sys_clk);
			if ((use_timer ? timer_irq : gpio_irq) === 1'b1) begin
				n++;
			end
		end
	endtask

	// Full reset then clean read-back of the control registers
	task automatic check_cleared();
		logic [31:0] d;
		wait_sys_rst(1'b0, 100);
		wb_read(soc_pkg::REG_GPIO_OUT, d);
		u_checker.compare_value("GPIO_OUT after reset", d, '0);
		wb_read(soc_pkg::REG_GPIO_IRQ_EN, d);
		u_checker.compare_value("IRQ_EN after reset", d, '0);
		wb_read(soc_pkg::REG_TIMER_CTRL, d);
		u_checker.compare_value("TIMER_CTRL after reset", d, '0);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		int flash_at;
		int rst_at;
		int n;
		int c;
		logic [31:0] r;
		logic [31:0] d;
		logic [3:0] bank;

		rng = 32'hd653;
		trigger_reset = 1'b1;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		btn = 3'd0;
		pcb_rev = 4'ha;
		repeat (5) @(posedge sys_clk);
		trigger_reset <= 1'b0;

		// Reset ordering with flash released first
		flash_at = 0;
		rst_at = 0;
		for (n = 1; n <= 200 && rst_at == 0; n++) begin
			@(posedge sys_clk);
			if (flash_rst_n === 1'b1 && flash_at == 0) flash_at = n;
			if (sys_rst === 1'b0) rst_at = n;
		end
		if (rst_at == 0) begin
			u_checker.note_failure("sys_rst_o never released after power-on reset");
		end
		u_checker.expect_true(flash_at != 0 && flash_at < rst_at,
			"flash reset not released before system reset");
		u_checker.expect_true(flash_at >= soc_pkg::FLASH_RST_CYCLES &&
			flash_at <= soc_pkg::FLASH_RST_CYCLES + 3, "flash reset hold length");
		u_checker.expect_true(rst_at >= soc_pkg::RST_HOLD_CYCLES &&
			rst_at <= soc_pkg::RST_HOLD_CYCLES + 3, "system reset hold length");

		// Random register traffic with every read compared in the checker
		repeat (60) begin
			r = next_rand();
			d = next_rand();
			bank = r[11:8];
			if (bank == soc_pkg::CSR_BANK_SYSCTL) bank = 4'd2;
			case (r[2:0])
				3'd0: wb_write(soc_pkg::REG_GPIO_OUT, d);
				3'd1: wb_write(soc_pkg::REG_GPIO_IRQ_EN, d);
				3'd2: wb_write(soc_pkg::REG_TIMER_COMPARE, d);
				3'd3: bus_access(1'b1, csr_addr(bank, r[21:12]), d, d);
				3'd4: wb_read(soc_pkg::REG_GPIO_OUT, d);
				3'd5: wb_read(soc_pkg::REG_GPIO_IRQ_EN, d);
				3'd6: wb_read(soc_pkg::REG_TIMER_COMPARE, d);
				default: bus_access(1'b0, csr_addr(bank, r[21:12]), '0, d);
			endcase
		end
		wb_read(soc_pkg::REG_SYSTEM_ID, d);
		u_checker.compare_value("SYSTEM_ID", d, soc_pkg::SYSTEM_ID);

		// GPIO inputs without all three buttons pressed
		repeat (8) begin
			r = next_rand();
			@(posedge sys_clk);
			btn <= 3'(r % 7);
			pcb_rev <= r[7:4];
			repeat (4) @(posedge sys_clk);
			wb_read(soc_pkg::REG_GPIO_IN, d);
		end

		// GPIO interrupt with only button 0 enabled
		@(posedge sys_clk);
		btn <= 3'b000;
		wb_write(soc_pkg::REG_GPIO_IRQ_EN, 32'h01);
		repeat (5) @(posedge sys_clk);
		btn <= 3'b001;
		count_pulses(1'b0, 10, n);
		u_checker.compare_value("gpio_irq pulses, enabled bit", n, 1);
		btn <= 3'b011;
		count_pulses(1'b0, 10, n);
		u_checker.compare_value("gpio_irq pulses, masked bit", n, 0);
		wb_write(soc_pkg::REG_GPIO_IRQ_EN, 32'h00);

		// Timer one-shot
		c = 20;
		wb_write(soc_pkg::REG_TIMER_COMPARE, c);
		wb_write(soc_pkg::REG_TIMER_COUNTER, 32'd0);
		wb_write(soc_pkg::REG_TIMER_CTRL, 32'd1);
		count_pulses(1'b1, 3 * (c + 4), n);
		u_checker.compare_value("one-shot timer pulses", n, 1);
		wb_read(soc_pkg::REG_TIMER_CTRL, d);

		// Timer autoreload with a period of compare+1
		c = 4 + int'(next_rand() % 32);
		wb_write(soc_pkg::REG_TIMER_COMPARE, c);
		wb_write(soc_pkg::REG_TIMER_COUNTER, 32'd0);
		wb_write(soc_pkg::REG_TIMER_CTRL, 32'd3);
		timer_gap(c + 10, n);
		repeat (2) begin
			timer_gap(c + 10, n);
			u_checker.compare_value("autoreload period", n, c + 1);
		end
		wb_write(soc_pkg::REG_TIMER_CTRL, 32'd0);

		// Hard reset through the register
		wb_write(soc_pkg::REG_GPIO_OUT, 32'd3);
		wb_write(soc_pkg::REG_GPIO_IRQ_EN, 32'h7f);
		wb_write(soc_pkg::REG_TIMER_CTRL, 32'd2);
		wb_write(soc_pkg::REG_HARD_RESET, 32'd0);
		wait_sys_rst(1'b1, 20);
		check_cleared();

		// Same through the three-button combination
		wb_write(soc_pkg::REG_GPIO_OUT, 32'd2);
		wb_write(soc_pkg::REG_GPIO_IRQ_EN, 32'h15);
		wb_write(soc_pkg::REG_TIMER_CTRL, 32'd1);
		@(posedge sys_clk);
		btn <= 3'b111;
		wait_sys_rst(1'b1, 20);
		@(posedge sys_clk);
		btn <= 3'b000;
		check_cleared();

		repeat (2) @(posedge sys_clk);
		u_checker.print_summary();
		if (u_checker.mismatch_count + u_checker.failure_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- soc_lite.f
source/soc_pkg.sv
source/soc_ifs.sv
source/reset_gen.sv
source/csr_bridge.sv
source/sysctl_regs.sv
source/sys_timer.sv
source/soc_top.sv
tests/soc_chk.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Makefile
SIM := obj_dir/Vtb_top
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): soc_lite.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f soc_lite.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
